//--- Makefile
# Verilator build, run, lint and clean for the operand fetch stage

VERILATOR ?= verilator
FILELIST  ?= files.f
TB_TOP    ?= operand_stage_tb
RTL_TOP   ?= operand_stage
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/1ps
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert --timescale $(TIMESCALE) -j $(JOBS)
LINTFLAGS ?= --lint-only -Wall --timing --timescale $(TIMESCALE)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

# Pass only when the log holds the pass line
run: build
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -q "^STATUS: PASS$$" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- common/operand_src_if.sv
// Interface with register read data and operand source selects, with modports

interface operand_src_if #(
	parameter int data_width = opstage_pkg::DATA_WIDTH_DEF
);
	import opstage_pkg::*;

	// Register file read data for both operands
	logic [data_width-1:0] rf_data_a;
	logic [data_width-1:0] rf_data_b;

	// Source of each operand, from the forwarding selector
	operand_sel_t sel_a;
	operand_sel_t sel_b;

	// Register file drives the read data
	modport rf_side (
		output rf_data_a,
		output rf_data_b
	);

	// Forwarding selector drives the selects
	modport fwd_side (
		output sel_a,
		output sel_b
	);

	// Operand mux consumes everything
	modport mux_side (
		input rf_data_a,
		input rf_data_b,
		input sel_a,
		input sel_b
	);

endinterface

//--- common/opstage_pkg.sv
// Operand source selector type and default operand and register number widths

package opstage_pkg;

	//////////////////////////////////////////////////
	// Default widths
	//////////////////////////////////////////////////

	// Width of one operand word
	localparam int DATA_WIDTH_DEF = 32;

	// Width of a register number
	// 5 bits address 32 general purpose registers
	localparam int ADDR_WIDTH_DEF = 5;

	//////////////////////////////////////////////////
	// Operand source selector
	//////////////////////////////////////////////////

	// Where the execute stage operand comes from
	// SEL_RF reads the register file
	// SEL_IMM takes the sign extended immediate (operand B only)
	// SEL_EX_FORW takes the result of the instruction now in execute
	// SEL_WB_FORW takes the result of the instruction now in write-back
	typedef enum logic [1:0] {
		SEL_RF      = 2'd0,
		SEL_IMM     = 2'd1,
		SEL_EX_FORW = 2'd2,
		SEL_WB_FORW = 2'd3
	} operand_sel_t;

	// Priority of the sources for one operand, highest first
	//   immediate (B side only)
	//   execute result
	//   write-back result
	//   register file
	// Register 0 is hardwired to zero and never forwarded

endpackage

//--- files.f
common/opstage_pkg.sv
common/operand_src_if.sv
regfile/reg_file.sv
verilog/fwd_select.sv
verilog/operand_mux.sv
verilog/operand_stage.sv
tests/operand_stage_tb.sv

//--- regfile/reg_file.sv
// Register file with two combinational read ports and one write port

module reg_file #(
	parameter int data_width = opstage_pkg::DATA_WIDTH_DEF,
	parameter int addr_width = opstage_pkg::ADDR_WIDTH_DEF
) (
	input  logic                  clk,
	input  logic                  arst_n,

	// Read addresses from decode
	input  logic [addr_width-1:0] addr_a,
	input  logic [addr_width-1:0] addr_b,

	// Write port from write-back
	input  logic                  wr_en,
	input  logic [addr_width-1:0] wr_addr,
	input  logic [data_width-1:0] wr_data,

	// Read data towards the operand mux
	operand_src_if.rf_side        rd
);

	// Number of registers addressed by addr_width bits
	localparam int num_regs = 2 ** addr_width;

	//////////////////////////////////////////////////
	// Storage
	//////////////////////////////////////////////////

	logic [data_width-1:0] regs [num_regs];

	// Write is qualified here
	// register 0 stays zero so writes to it are dropped
	logic wr_take;

	assign wr_take = wr_en && (wr_addr != '0);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			// Whole array comes up as zero
			for (int i = 0; i < num_regs; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_take) begin
			regs[wr_addr] <= wr_data;
		end
	end

	//////////////////////////////////////////////////
	// Read ports
	//////////////////////////////////////////////////

	// Combinational reads
	// A write in this cycle shows up next cycle
	// same cycle hazard is covered by WB forwarding
	always_comb begin
		if (addr_a == '0) begin
			rd.rf_data_a = '0;
		end else begin
			rd.rf_data_a = regs[addr_a];
		end
	end

	always_comb begin
		if (addr_b == '0) begin
			rd.rf_data_b = '0;
		end else begin
			rd.rf_data_b = regs[addr_b];
		end
	end

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	// Write-back must hand over known data whenever it writes
	a_wr_data_known: assert property (@(posedge clk) disable iff (!arst_n)
		wr_en |-> !$isunknown(wr_data))
		else $error("reg_file: unknown write data to r%0d", wr_addr);

endmodule

//--- tests/operand_stage_tb.sv
// Directed testbench for the operand fetch stage with a reference register model

module operand_stage_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import opstage_pkg::*;

	localparam int dw = DATA_WIDTH_DEF;
	localparam int aw = ADDR_WIDTH_DEF;
	localparam int clk_period = 40;

	// Cycles per test with reset first
	// reset 4, rf path 16, ex 1, wb 3, imm 2, freeze 12
	localparam int test_cycles = 4 + 16 + 1 + 3 + 2 + 12;
	localparam int timeout_ns = (test_cycles + 20) * clk_period;

	logic          clk;
	logic          arst_n;
	logic          id_freeze;
	logic          ex_freeze;
	logic [aw-1:0] addr_a;
	logic [aw-1:0] addr_b;
	logic          use_imm;
	logic [dw-1:0] simm;
	logic          ex_valid;
	logic [aw-1:0] ex_dest;
	logic [dw-1:0] ex_result;
	logic          wb_valid;
	logic [aw-1:0] wb_dest;
	logic [dw-1:0] wb_result;
	logic [dw-1:0] muxed_a;
	logic [dw-1:0] muxed_b;
	logic [dw-1:0] operand_a;
	logic [dw-1:0] operand_b;

	// Reference register contents
	logic [dw-1:0] ref_regs [2 ** aw];
	integer        seed;

	operand_stage #(
		.data_width (dw),
		.addr_width (aw)
	) dut0 (
		.clk       (clk),
		.arst_n    (arst_n),
		.id_freeze (id_freeze),
		.ex_freeze (ex_freeze),
		.addr_a    (addr_a),
		.addr_b    (addr_b),
		.use_imm   (use_imm),
		.simm      (simm),
		.ex_valid  (ex_valid),
		.ex_dest   (ex_dest),
		.ex_result (ex_result),
		.wb_valid  (wb_valid),
		.wb_dest   (wb_dest),
		.wb_result (wb_result),
		.muxed_a   (muxed_a),
		.muxed_b   (muxed_b),
		.operand_a (operand_a),
		.operand_b (operand_b)
	);

	// 40 ns clock
	always #(clk_period / 2) clk = ~clk;

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	function automatic logic [aw-1:0] to_reg(input int n);
		return aw'(n);
	endfunction

	// One edge where the model takes the write-back
	// then on to the drive point 2 ns later
	task automatic tick();
		@(posedge clk);
		if (wb_valid && wb_dest != '0) begin
			ref_regs[wb_dest] = wb_result;
		end
		#2;
	endtask

	// Combinational outputs are settled by mid cycle
	task automatic wait_mid_cycle();
		@(negedge clk);
	endtask

	// No hazards, no immediate, reads of r0
	task automatic idle_inputs();
		addr_a    = '0;
		addr_b    = '0;
		use_imm   = 1'b0;
		simm      = '0;
		ex_valid  = 1'b0;
		ex_dest   = '0;
		ex_result = '0;
		wb_valid  = 1'b0;
		wb_dest   = '0;
		wb_result = '0;
	endtask

	// Random traffic that must not reach frozen operands
	task automatic scramble_inputs();
		addr_a    = aw'($random(seed));
		addr_b    = aw'($random(seed));
		use_imm   = 1'($random(seed));
		simm      = dw'($random(seed));
		ex_valid  = 1'b1;
		ex_dest   = addr_a;
		ex_result = dw'($random(seed));
	endtask

	task automatic check_value(input string test, input logic [dw-1:0] expected,
		input logic [dw-1:0] actual);
		assert (actual === expected) else begin
			$display("ERR %s expected %h actual %h", test, expected, actual);
			$display("STATUS: FAIL");
			$fatal(1, "mismatch in test %s", test);
		end
	endtask

	//////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////

	task automatic test_reset_rf();
		check_value("reset_rf", '0, operand_a);
		check_value("reset_rf", '0, operand_b);
		// Fill r0..r7
		// The r0 write must vanish
		for (int i = 0; i < 8; i++) begin
			wb_valid  = 1'b1;
			wb_dest   = to_reg(i);
			wb_result = dw'($random(seed));
			tick();
		end
		idle_inputs();
		// Read back in crossed pairs
		// Operands follow one edge later
		for (int i = 0; i < 8; i++) begin
			addr_a = to_reg(i);
			addr_b = to_reg(7 - i);
			wait_mid_cycle();
			check_value("reset_rf", ref_regs[i], muxed_a);
			check_value("reset_rf", ref_regs[7 - i], muxed_b);
			tick();
			check_value("reset_rf", ref_regs[i], operand_a);
			check_value("reset_rf", ref_regs[7 - i], operand_b);
		end
		idle_inputs();
	endtask

	// EX and WB both hit and EX is younger
	task automatic test_ex_forward();
		logic [dw-1:0] exp;
		exp       = dw'($random(seed));
		addr_a    = to_reg(4);
		addr_b    = to_reg(4);
		ex_valid  = 1'b1;
		ex_dest   = to_reg(4);
		ex_result = exp;
		wb_valid  = 1'b1;
		wb_dest   = to_reg(4);
		wb_result = ~exp;
		wait_mid_cycle();
		check_value("ex_forward", exp, muxed_a);
		check_value("ex_forward", exp, muxed_b);
		tick();
		check_value("ex_forward", exp, operand_a);
		idle_inputs();
	endtask

	task automatic test_wb_forward();
		logic [dw-1:0] exp;
		exp = dw'($random(seed));
		// Must differ from what r6 holds now
		if (exp === ref_regs[6]) begin
			exp = ~exp;
		end
		addr_a    = to_reg(6);
		addr_b    = to_reg(6);
		wb_valid  = 1'b1;
		wb_dest   = to_reg(6);
		wb_result = exp;
		wait_mid_cycle();
		check_value("wb_forward", exp, muxed_a);
		check_value("wb_forward", exp, muxed_b);
		tick();
		// Now a plain register read
		// Stale write-back data differs so only the register file can match
		wb_valid  = 1'b0;
		wb_result = ~exp;
		wait_mid_cycle();
		check_value("wb_forward", exp, muxed_a);
		check_value("wb_forward", exp, muxed_b);
		tick();
		// Hazards on r0 are not forwarded
		addr_a    = '0;
		addr_b    = '0;
		wb_valid  = 1'b1;
		wb_dest   = '0;
		wb_result = exp | 1;
		ex_valid  = 1'b1;
		ex_dest   = '0;
		ex_result = ~exp | 1;
		wait_mid_cycle();
		check_value("wb_forward", '0, muxed_a);
		check_value("wb_forward", '0, muxed_b);
		tick();
		idle_inputs();
	endtask

	// Immediate beats an EX hit on B while A still forwards
	task automatic test_immediate();
		use_imm   = 1'b1;
		simm      = dw'($random(seed));
		addr_a    = to_reg(9);
		addr_b    = to_reg(9);
		ex_valid  = 1'b1;
		ex_dest   = to_reg(9);
		ex_result = dw'($random(seed));
		wait_mid_cycle();
		check_value("immediate", simm, muxed_b);
		check_value("immediate", ex_result, muxed_a);
		tick();
		check_value("immediate", simm, operand_b);
		check_value("immediate", ex_result, operand_a);
		// A without a hazard reads the register file
		addr_a = to_reg(2);
		wait_mid_cycle();
		check_value("immediate", ref_regs[2], muxed_a);
		check_value("immediate", simm, muxed_b);
		tick();
		idle_inputs();
	endtask

	task automatic test_freeze();
		logic [dw-1:0] hold_a;
		logic [dw-1:0] hold_b;
		// Known load first
		addr_a = to_reg(1);
		addr_b = to_reg(2);
		tick();
		hold_a = ref_regs[1];
		hold_b = ref_regs[2];
		check_value("freeze", hold_a, operand_a);
		check_value("freeze", hold_b, operand_b);
		// Execute stalled
		ex_freeze = 1'b1;
		for (int i = 0; i < 4; i++) begin
			scramble_inputs();
			tick();
			check_value("freeze", hold_a, operand_a);
			check_value("freeze", hold_b, operand_b);
		end
		ex_freeze = 1'b0;
		idle_inputs();
		addr_a = to_reg(3);
		addr_b = to_reg(4);
		tick();
		check_value("freeze", ref_regs[3], operand_a);
		check_value("freeze", ref_regs[4], operand_b);
		// Decode stalled so capture once then hold
		id_freeze = 1'b1;
		addr_a    = to_reg(5);
		addr_b    = to_reg(6);
		tick();
		hold_a = ref_regs[5];
		hold_b = ref_regs[6];
		check_value("freeze", hold_a, operand_a);
		check_value("freeze", hold_b, operand_b);
		for (int i = 0; i < 3; i++) begin
			scramble_inputs();
			tick();
			check_value("freeze", hold_a, operand_a);
			check_value("freeze", hold_b, operand_b);
		end
		// Release gives one more held edge then a fresh load
		id_freeze = 1'b0;
		idle_inputs();
		addr_a = to_reg(2);
		addr_b = to_reg(3);
		tick();
		check_value("freeze", hold_a, operand_a);
		check_value("freeze", hold_b, operand_b);
		tick();
		check_value("freeze", ref_regs[2], operand_a);
		check_value("freeze", ref_regs[3], operand_b);
	endtask

	//////////////////////////////////////////////////
	// Sequence and watchdog
	//////////////////////////////////////////////////

	initial begin
		seed      = 64;
		clk       = 1'b0;
		arst_n    = 1'b0;
		id_freeze = 1'b0;
		ex_freeze = 1'b0;
		idle_inputs();
		for (int i = 0; i < 2 ** aw; i++) begin
			ref_regs[i] = '0;
		end
		repeat (4) @(posedge clk);
		#2;
		arst_n = 1'b1;
		test_reset_rf();
		test_ex_forward();
		test_wb_forward();
		test_immediate();
		test_freeze();
		$display("STATUS: PASS");
		$finish;
	end

	initial begin
		#(timeout_ns);
		$display("Timeout: tests still running after %0d ns", timeout_ns);
		$display("STATUS: FAIL");
		$fatal(1, "watchdog expired");
	end

endmodule

//--- verilog/fwd_select.sv
// Forwarding selector choosing each operand source from the EX and WB destinations

module fwd_select #(
	parameter int addr_width = opstage_pkg::ADDR_WIDTH_DEF
) (
	// Clock and reset serve the checks only
	input  logic                  clk,
	input  logic                  arst_n,

	// Source register numbers from decode
	input  logic [addr_width-1:0] addr_a,
	input  logic [addr_width-1:0] addr_b,

	// Operand B takes the immediate
	input  logic                  use_imm,

	// Instruction in execute
	input  logic                  ex_valid,
	input  logic [addr_width-1:0] ex_dest,

	// Instruction in write-back
	input  logic                  wb_valid,
	input  logic [addr_width-1:0] wb_dest,

	// Resulting selects
	operand_src_if.fwd_side       sel
);
	import opstage_pkg::*;

	//////////////////////////////////////////////////
	// Hazard detection
	//////////////////////////////////////////////////

	// Register 0 is never a real dependency
	logic a_nonzero;
	logic b_nonzero;

	// Per stage matches
	logic ex_hit_a;
	logic ex_hit_b;
	logic wb_hit_a;
	logic wb_hit_b;

	assign a_nonzero = (addr_a != '0);
	assign b_nonzero = (addr_b != '0);

	assign ex_hit_a = ex_valid && (ex_dest == addr_a) && a_nonzero;
	assign ex_hit_b = ex_valid && (ex_dest == addr_b) && b_nonzero;
	assign wb_hit_a = wb_valid && (wb_dest == addr_a) && a_nonzero;
	assign wb_hit_b = wb_valid && (wb_dest == addr_b) && b_nonzero;

	//////////////////////////////////////////////////
	// Source selection
	//////////////////////////////////////////////////

	// A side never sees the immediate
	// EX is the younger result so it wins over WB
	always_comb begin
		if (ex_hit_a) begin
			sel.sel_a = SEL_EX_FORW;
		end else if (wb_hit_a) begin
			sel.sel_a = SEL_WB_FORW;
		end else begin
			sel.sel_a = SEL_RF;
		end
	end

	// Immediate overrides any hazard on B
	always_comb begin
		if (use_imm) begin
			sel.sel_b = SEL_IMM;
		end else if (ex_hit_b) begin
			sel.sel_b = SEL_EX_FORW;
		end else if (wb_hit_b) begin
			sel.sel_b = SEL_WB_FORW;
		end else begin
			sel.sel_b = SEL_RF;
		end
	end

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	// The operand mux has no immediate input on A
	a_no_imm_on_a: assert property (@(posedge clk) disable iff (!arst_n)
		sel.sel_a != SEL_IMM)
		else $error("fwd_select: immediate selected for operand A");

	// Forwarding into r0 would break the hardwired zero
	a_no_fwd_r0: assert property (@(posedge clk) disable iff (!arst_n)
		((sel.sel_a inside {SEL_EX_FORW, SEL_WB_FORW}) -> a_nonzero) &&
		((sel.sel_b inside {SEL_EX_FORW, SEL_WB_FORW}) -> b_nonzero))
		else $error("fwd_select: forward chosen for register 0");

endmodule

//--- verilog/operand_mux.sv
// Operand mux selecting each operand and latching it for execute under the freezes

module operand_mux #(
	parameter int data_width = opstage_pkg::DATA_WIDTH_DEF
) (
	input  logic                  clk,
	input  logic                  arst_n,

	// Pipeline freezes
	input  logic                  id_freeze,
	input  logic                  ex_freeze,

	// Immediate and forwarded results
	input  logic [data_width-1:0] simm,
	input  logic [data_width-1:0] ex_forw,
	input  logic [data_width-1:0] wb_forw,

	// Register data and selects
	operand_src_if.mux_side       src,

	// Combinational operand values
	output logic [data_width-1:0] muxed_a,
	output logic [data_width-1:0] muxed_b,

	// Operands latched for execute
	output logic [data_width-1:0] operand_a,
	output logic [data_width-1:0] operand_b
);
	import opstage_pkg::*;

	//////////////////////////////////////////////////
	// Source muxes
	//////////////////////////////////////////////////

	// A side has no immediate
	// SEL_IMM cannot occur here and falls back to register data
	always_comb begin
		case (src.sel_a)
			SEL_EX_FORW: muxed_a = ex_forw;
			SEL_WB_FORW: muxed_a = wb_forw;
			default:     muxed_a = src.rf_data_a;
		endcase
	end

	always_comb begin
		case (src.sel_b)
			SEL_IMM:     muxed_b = simm;
			SEL_EX_FORW: muxed_b = ex_forw;
			SEL_WB_FORW: muxed_b = wb_forw;
			default:     muxed_b = src.rf_data_b;
		endcase
	end

	//////////////////////////////////////////////////
	// Operand registers
	//////////////////////////////////////////////////

	// Index 0 is operand A, index 1 is operand B
	logic [1:0][data_width-1:0] muxed_v;
	logic [1:0][data_width-1:0] operand_q;

	// Set once an operand has been captured under id_freeze
	logic [1:0] saved_q;

	assign muxed_v[0] = muxed_a;
	assign muxed_v[1] = muxed_b;

	// Latch rule per operand
	//   ex_freeze holds operand and flag
	//   flag clear loads the muxed value
	//   id_freeze on a load sets the flag
	//   flag set with both freezes low clears it and holds one more edge
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			operand_q <= '0;
			saved_q   <= '0;
		end else if (!ex_freeze) begin
			for (int i = 0; i < 2; i++) begin
				if (!saved_q[i]) begin
					operand_q[i] <= muxed_v[i];
					if (id_freeze) begin
						saved_q[i] <= 1'b1;
					end
				end else if (!id_freeze) begin
					saved_q[i] <= 1'b0;
				end
			end
		end
	end

	assign operand_a = operand_q[0];
	assign operand_b = operand_q[1];

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	for (genvar i = 0; i < 2; i++) begin : g_chk
		// Free running pipe tracks the mux one edge later
		a_load: assert property (@(posedge clk) disable iff (!arst_n)
			(!ex_freeze && !id_freeze && !saved_q[i])
			|=> (operand_q[i] == $past(muxed_v[i])))
			else $error("operand_mux: operand %0d missed its load", i);

		// Execute stalled means its operands must not move
		a_hold: assert property (@(posedge clk) disable iff (!arst_n)
			ex_freeze |=> $stable(operand_q[i]))
			else $error("operand_mux: operand %0d changed under ex_freeze", i);
	end

endmodule

//--- verilog/operand_stage.sv
// Operand fetch stage top level with register file, forwarding selector and operand mux

module operand_stage #(
	parameter int data_width = opstage_pkg::DATA_WIDTH_DEF,
	parameter int addr_width = opstage_pkg::ADDR_WIDTH_DEF
) (
	input  logic                  clk,
	input  logic                  arst_n,

	// Pipeline freezes
	input  logic                  id_freeze,
	input  logic                  ex_freeze,

	// Decode side
	input  logic [addr_width-1:0] addr_a,
	input  logic [addr_width-1:0] addr_b,
	input  logic                  use_imm,
	input  logic [data_width-1:0] simm,

	// Execute stage result
	input  logic                  ex_valid,
	input  logic [addr_width-1:0] ex_dest,
	input  logic [data_width-1:0] ex_result,

	// Write-back stage result, also the register file write port
	input  logic                  wb_valid,
	input  logic [addr_width-1:0] wb_dest,
	input  logic [data_width-1:0] wb_result,

	// Operands
	output logic [data_width-1:0] muxed_a,
	output logic [data_width-1:0] muxed_b,
	output logic [data_width-1:0] operand_a,
	output logic [data_width-1:0] operand_b
);

	// Read data and selects shared by the three blocks
	operand_src_if #(.data_width(data_width)) src_if ();

	// Register file, written from write-back
	reg_file #(
		.data_width (data_width),
		.addr_width (addr_width)
	) u_reg_file (
		.clk     (clk),
		.arst_n  (arst_n),
		.addr_a  (addr_a),
		.addr_b  (addr_b),
		.wr_en   (wb_valid),
		.wr_addr (wb_dest),
		.wr_data (wb_result),
		.rd      (src_if.rf_side)
	);

	// Hazard check against execute and write-back
	fwd_select #(
		.addr_width (addr_width)
	) u_fwd_select (
		.clk      (clk),
		.arst_n   (arst_n),
		.addr_a   (addr_a),
		.addr_b   (addr_b),
		.use_imm  (use_imm),
		.ex_valid (ex_valid),
		.ex_dest  (ex_dest),
		.wb_valid (wb_valid),
		.wb_dest  (wb_dest),
		.sel      (src_if.fwd_side)
	);

	// Operand selection and execute stage registers
	operand_mux #(
		.data_width (data_width)
	) u_operand_mux (
		.clk       (clk),
		.arst_n    (arst_n),
		.id_freeze (id_freeze),
		.ex_freeze (ex_freeze),
		.simm      (simm),
		.ex_forw   (ex_result),
		.wb_forw   (wb_result),
		.src       (src_if.mux_side),
		.muxed_a   (muxed_a),
		.muxed_b   (muxed_b),
		.operand_a (operand_a),
		.operand_b (operand_b)
	);

endmodule
